//--- Bender.yml
package:
  name: umi_crossbar

sources:
  - include_dirs:
      - common
    files:
      - common/umi_pkg.sv
      - design/umi_vmux.sv
      - design/umi_arbiter.sv
      - design/umi_crossbar.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - sim/umi_crossbar_sva.sv
      - sim/umi_crossbar_tb.sv

//--- common/umi_pkg.sv
// UMI shared types: packet struct and arbiter mode encoding

`include "umi_settings.svh"

package umi_pkg;

   // ##############################
   // Packet
   // ##############################

   // One UMI transaction as it crosses the switch
   // Field order from the top: cmd, dstaddr, srcaddr, data
   typedef struct packed {
      logic [`UMI_CW-1:0] cmd;      // Opcode and control
      logic [`UMI_AW-1:0] dstaddr;  // Where it goes
      logic [`UMI_AW-1:0] srcaddr;  // Where replies return
      logic [`UMI_DW-1:0] data;     // Payload
   } umi_packet_t;

   // Whole struct travels on one bus per port,
   // so muxing never splits fields apart

   // ##############################
   // Arbiter mode
   // ##############################

   // Two-bit mode shared by all output arbiters
   // 0 keeps the lowest index on top, as on earlier UMI switches
   typedef enum logic [1:0] {
      ARB_FIXED      = 2'd0,  // Lowest index wins
      ARB_ROUNDROBIN = 2'd1,  // Rotating pointer per output
      ARB_RSVD2      = 2'd2,  // Reserved, runs as fixed
      ARB_RSVD3      = 2'd3   // Reserved, runs as fixed
   } arb_mode_e;

   // Reserved codes are decoded as fixed priority in the arbiter
   // so software writing junk still gets a working switch

   // Mode is quasi-static
   // Changing it mid-traffic is legal, pointers are kept

endpackage

//--- common/umi_settings.svh
// UMI crossbar settings: port count and packet field widths

`ifndef UMI_SETTINGS_SVH
`define UMI_SETTINGS_SVH

// ##############################
// Crossbar size
// ##############################

// Ports on each side, inputs and outputs alike
`define UMI_N 4

// ##############################
// Packet fields
// ##############################

// Command word, opcode plus size and length fields
`define UMI_CW 32

// Destination and source addresses
`define UMI_AW 64

// Data payload
`define UMI_DW 64

// Packet is CW + 2*AW + DW = 224 bits with the defaults above
// Keep widths multiples of 8 so byte lanes line up downstream

`endif

//--- design/umi_arbiter.sv
// UMI output arbiter, fixed priority or round robin with per-path masking

module umi_arbiter #(
   parameter int N = 4                              // Number of requesters
) (
   input  logic               clk,
   input  logic               rst_n,
   input  umi_pkg::arb_mode_e mode,                 // Fixed or round robin
   input  logic [N-1:0]       mask,                 // 1 disables a path
   input  logic [N-1:0]       requests,             // One bit per input
   input  logic               ready,                // Output accepts
   output logic [N-1:0]       grants                // One-hot or zero
);

   localparam int PW = (N > 1) ? $clog2(N) : 1;     // Pointer width

   logic [N-1:0]  req_en;        // Requests left after masking
   logic [N-1:0]  grant_fixed;   // Lowest index winner
   logic [N-1:0]  grant_rr;      // Round robin winner
   logic [PW-1:0] win_fixed;
   logic [PW-1:0] win_rr;
   logic [PW-1:0] win_idx;       // Index of the active grant
   logic [PW-1:0] rr_ptr;        // Highest priority input
   logic [PW-1:0] rr_ptr_nxt;
   logic          xfer;          // Grant taken this cycle

   // ##############################
   // Request masking
   // ##############################

   // Disabled paths never compete
   assign req_en = requests & ~mask;

   // ##############################
   // Fixed priority
   // ##############################

   // Walk down from the top, last hit is the lowest index
   always_comb
   begin
      grant_fixed = '0;
      win_fixed   = '0;
      for (int i = N - 1; i >= 0; i--)
      begin
         if (req_en[i])
         begin
            grant_fixed    = '0;          // Drop higher hit
            grant_fixed[i] = 1'b1;
            win_fixed      = PW'(i);
         end
      end
   end

   // ##############################
   // Round robin
   // ##############################

   // Search starts at the pointer and wraps past N-1
   always_comb
   begin
      int   idx;
      logic found;
      grant_rr = '0;
      win_rr   = '0;
      found    = 1'b0;
      for (int i = 0; i < N; i++)
      begin
         idx = int'(rr_ptr) + i;
         if (idx >= N)
         begin
            idx = idx - N;                // Wrap around
         end
         if (!found && req_en[idx])
         begin
            found         = 1'b1;         // First hit wins
            grant_rr[idx] = 1'b1;
            win_rr        = PW'(idx);
         end
      end
   end

   // Mode select, reserved codes behave as fixed
   always_comb
   begin
      case (mode)
         umi_pkg::ARB_ROUNDROBIN:
         begin
            grants  = grant_rr;
            win_idx = win_rr;
         end
         default:
         begin
            grants  = grant_fixed;
            win_idx = win_fixed;
         end
      endcase
   end

   // ##############################
   // Pointer update
   // ##############################

   // Transfer needs a grant and a ready output
   assign xfer = ready & (|grants);

   // One past the winner, wrapping at N-1
   assign rr_ptr_nxt = (int'(win_idx) == N - 1) ? '0 : win_idx + 1'b1;

   // Pointer tracks every transfer, so it is warm when mode flips.
   // Back-pressure holds it where it is.
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         rr_ptr <= '0;                    // Input 0 on top
      end
      else if (xfer)
      begin
         rr_ptr <= rr_ptr_nxt;
      end
   end

endmodule

//--- design/umi_crossbar.sv
// UMI crossbar top, non-blocking N by N switch with one arbiter per output

`include "umi_settings.svh"

module umi_crossbar (
   input  logic                              clk,
   input  logic                              rst_n,
   input  umi_pkg::arb_mode_e                mode,        // Shared arbiter mode
   input  logic [`UMI_N*`UMI_N-1:0]          mask,        // 1 disables a path
   // Incoming side
   input  logic [`UMI_N*`UMI_N-1:0]          in_request,  // Bit N*k+j, in j to out k
   input  umi_pkg::umi_packet_t [`UMI_N-1:0] in_packet,
   output logic [`UMI_N-1:0]                 in_ready,
   // Outgoing side
   output logic [`UMI_N-1:0]                 out_valid,
   output umi_pkg::umi_packet_t [`UMI_N-1:0] out_packet,
   input  logic [`UMI_N-1:0]                 out_ready
);

   localparam int N = `UMI_N;

   // Matrix layouts
   //   output-major: bit N*k+j = input j, output k
   //   input-major:  bit N*j+k = input j, output k
   logic [N*N-1:0] grants;       // Output-major, from arbiters
   logic [N*N-1:0] grants_t;     // Input-major copy
   logic [N*N-1:0] request_t;    // Input-major copy

   // ##############################
   // Arbiters, one per output
   // ##############################

   for (genvar k = 0; k < N; k++)
   begin : g_arb
      umi_arbiter #(
         .N        (N)
      ) u_arb (
         .clk      (clk),
         .rst_n    (rst_n),
         .mode     (mode),
         .mask     (mask[N*k+:N]),          // Slice k
         .requests (in_request[N*k+:N]),
         .ready    (out_ready[k]),          // Moves the pointer
         .grants   (grants[N*k+:N])
      );

      // Any grant on the slice means a packet is presented
      assign out_valid[k] = |grants[N*k+:N];
   end

   // ##############################
   // Muxes, one per output
   // ##############################

   for (genvar k = 0; k < N; k++)
   begin : g_mux
      umi_vmux #(
         .N   (N)
      ) u_mux (
         .sel (grants[N*k+:N]),             // Grant slice k
         .in  (in_packet),                  // All inputs
         .out (out_packet[k])
      );
   end

   // ##############################
   // Input ready
   // ##############################

   // Flip the matrices so each input sees its own row
   for (genvar j = 0; j < N; j++)
   begin : g_in
      for (genvar k = 0; k < N; k++)
      begin : g_out
         assign grants_t[N*j+k]  = grants[N*k+j];
         assign request_t[N*j+k] = in_request[N*k+j];
      end

      // Ready unless a requested output is lost or stalled.
      // Idle inputs read ready, harmless since nothing is offered.
      assign in_ready[j] = ~|(request_t[N*j+:N] &
                              (~grants_t[N*j+:N] | ~out_ready));
   end

   // Whole path is combinational, zero cycles request to output
   // Only state is the pointer inside each arbiter

endmodule

//--- design/umi_vmux.sv
// One-hot select mux, steers a single UMI packet out of N candidates

module umi_vmux #(
   parameter int N = 4                                 // Number of candidates
) (
   input  logic [N-1:0]                     sel,       // One-hot or zero
   input  umi_pkg::umi_packet_t [N-1:0]     in,        // All input packets
   output umi_pkg::umi_packet_t             out        // Selected packet
);

   // ##############################
   // AND-OR select
   // ##############################

   // No priority chain here
   // Select is one-hot, so OR of gated packets is the pick
   // Zero select gives zero out, lets synthesis prune dead paths

   always_comb
   begin
      out = '0;                                 // Idle value
      for (int i = 0; i < N; i++)
      begin
         if (sel[i])
         begin
            out = out | in[i];                  // Gate and merge
         end
      end
   end

   // Two select bits at once would merge packets
   // Arbiter grants guarantee that never happens

endmodule

//--- flist.f
+incdir+common
common/umi_pkg.sv
design/umi_vmux.sv
design/umi_arbiter.sv
design/umi_crossbar.sv
sim/umi_crossbar_sva.sv
sim/umi_crossbar_tb.sv

//--- sim/umi_crossbar_sva.sv
// UMI crossbar assertions on request, grant and input ready rules

`include "umi_settings.svh"

module umi_crossbar_sva (
   input logic                     clk,
   input logic                     rst_n,
   input logic [`UMI_N*`UMI_N-1:0] mask,
   input logic [`UMI_N*`UMI_N-1:0] in_request,   // Output-major
   input logic [`UMI_N*`UMI_N-1:0] grants,       // Output-major
   input logic [`UMI_N-1:0]        in_ready,
   input logic [`UMI_N-1:0]        out_ready
);

   localparam int N = `UMI_N;

   // ##############################
   // Per input
   // ##############################

   for (genvar j = 0; j < N; j++)
   begin : g_in
      logic [N-1:0] row;                          // Targets of input j
      for (genvar k = 0; k < N; k++)
      begin : g_out
         assign row[k] = in_request[N*k+j];
         // Ready toward a stalled output would drop a packet
         a_ready_target : assert property (@(posedge clk) disable iff (!rst_n)
            in_ready[j] && in_request[N*k+j] |-> out_ready[k])
            else $error("input %0d ready while output %0d stalls", j, k);
      end
      a_one_target : assert property (@(posedge clk) disable iff (!rst_n)
         $onehot0(row))
         else $error("input %0d requests several outputs", j);
   end

   // ##############################
   // Per output
   // ##############################

   for (genvar k = 0; k < N; k++)
   begin : g_grant
      a_grant_onehot : assert property (@(posedge clk) disable iff (!rst_n)
         $onehot0(grants[N*k+:N]))
         else $error("output %0d grants several inputs", k);
      a_grant_mask : assert property (@(posedge clk) disable iff (!rst_n)
         (grants[N*k+:N] & mask[N*k+:N]) == '0)
         else $error("output %0d grants a masked path", k);
   end

endmodule

bind umi_crossbar umi_crossbar_sva u_sva (
   .clk        (clk),
   .rst_n      (rst_n),
   .mask       (mask),
   .in_request (in_request),
   .grants     (grants),
   .in_ready   (in_ready),
   .out_ready  (out_ready)
);

//--- sim/umi_crossbar_tb.sv
// UMI crossbar testbench, random traffic checked against a reference model

`include "umi_settings.svh"

module umi_crossbar_tb;

   localparam int N             = `UMI_N;
   localparam int PHASE_CYCLES  = 400;
   localparam int MAX_CYCLES    = 4 * PHASE_CYCLES + 400;  // Phases plus resets and slack
   localparam int WITHDRAW_WAIT = 6;                       // Cycles before a masked request drops

   logic                         clk;
   logic                         rst_n;
   umi_pkg::arb_mode_e           mode;
   logic [N*N-1:0]               mask;
   logic [N*N-1:0]               in_request;
   umi_pkg::umi_packet_t [N-1:0] in_packet;
   logic [N-1:0]                 in_ready;
   logic [N-1:0]                 out_valid;
   umi_pkg::umi_packet_t [N-1:0] out_packet;
   logic [N-1:0]                 out_ready;

   integer               seed;
   int                   errors;
   int                   transfers;
   int                   cycle_cnt = 0;
   // Phase knobs, applied on the next stimulus edge
   umi_pkg::arb_mode_e   ph_mode;
   logic [N*N-1:0]       ph_mask;
   int                   ready_pct;
   int                   idle_pct;
   logic                 contend;     // All inputs aim at output 0
   logic                 count_fair;
   // Per input traffic state
   logic                 active [N];
   logic                 accepted [N];
   int                   tgt [N];
   int                   seq_no [N];
   int                   wait_cnt [N];
   umi_pkg::umi_packet_t cur_pkt [N];
   int                   acc_cnt [N];
   int                   deliv_cnt [N];
   int                   fair_cnt [N];
   // Reference model state
   int                   model_ptr [N];
   logic [N*N-1:0]       prev_req;
   logic [N*N-1:0]       prev_grants;
   logic [N-1:0]         prev_ready;
   logic                 prev_ok;
   int                   fmin;
   int                   fmax;

   umi_crossbar uut (
      .clk        (clk),
      .rst_n      (rst_n),
      .mode       (mode),
      .mask       (mask),
      .in_request (in_request),
      .in_packet  (in_packet),
      .in_ready   (in_ready),
      .out_valid  (out_valid),
      .out_packet (out_packet),
      .out_ready  (out_ready)
   );

   always #10 clk = ~clk;                // Period 20

   // ##############################
   // Run limit
   // ##############################

   always @(posedge clk)
   begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= MAX_CYCLES)
      begin
         $display("Timeout after %0d cycles, the testbench hung", MAX_CYCLES);
         $display("Simulation finished: FAIL");
         $finish;
      end
   end

   task automatic report_mismatch(input string name, input logic [255:0] exp_v,
                                  input logic [255:0] act_v);
      $display("CHECK FAILED %s: expected %0h, actual %0h (cycle %0d)",
               name, exp_v, act_v, cycle_cnt);
      errors++;
   endtask

   // New target and packet for input j, or idle
   task automatic pick_request(input int j);
      int r;
      r = $unsigned($random(seed)) % 100;
      active[j]   = (r >= idle_pct);
      tgt[j]      = contend ? 0 : $unsigned($random(seed)) % N;
      wait_cnt[j] = 0;
      cur_pkt[j].cmd     = {8'(j), 8'(tgt[j]), 16'(seq_no[j])};   // Source, target, sequence
      cur_pkt[j].dstaddr = {$random(seed), $random(seed)};
      cur_pkt[j].srcaddr = {$random(seed), $random(seed)};
      cur_pkt[j].data    = {$random(seed), $random(seed)};
   endtask

   // Rising edge drive, inputs hold until accepted
   task automatic next_stimulus();
      logic [N*N-1:0]               req;
      logic [N-1:0]                 rdy;
      umi_pkg::umi_packet_t [N-1:0] pkts;
      req = '0;
      if (ph_mode != mode || ph_mask != mask)
      begin
         prev_ok = 1'b0;                 // Hold rule only within a phase
      end
      for (int j = 0; j < N; j++)
      begin
         if (accepted[j])
         begin
            seq_no[j]++;
         end
         if (!active[j] || accepted[j] ||
             (mask[N*tgt[j]+j] && wait_cnt[j] >= WITHDRAW_WAIT))
         begin
            pick_request(j);             // Masked waits get withdrawn here
         end
         accepted[j] = 1'b0;
         if (active[j])
         begin
            req[N*tgt[j]+j] = 1'b1;
         end
         pkts[j] = active[j] ? cur_pkt[j] : '0;
         rdy[j]  = ($unsigned($random(seed)) % 100) < ready_pct;
      end
      mode       <= ph_mode;
      mask       <= ph_mask;
      in_request <= req;
      in_packet  <= pkts;
      out_ready  <= rdy;
   endtask

   // ##############################
   // Reference model and checks
   // ##############################

   task automatic check_cycle();
      logic [N*N-1:0]       exp_grants;
      logic [N-1:0]         exp_valid;
      logic [N-1:0]         exp_ready;
      umi_pkg::umi_packet_t exp_pkt;
      int                   win [N];
      int                   cand;
      int                   src;
      int                   dst;
      int                   sq;
      exp_grants = '0;
      exp_valid  = '0;
      exp_ready  = '1;
      for (int k = 0; k < N; k++)
      begin
         win[k] = -1;
         for (int p = 0; p < N; p++)
         begin
            cand = (mode == umi_pkg::ARB_ROUNDROBIN) ? (model_ptr[k] + p) % N : p;
            if (win[k] < 0 && in_request[N*k+cand] && !mask[N*k+cand])
            begin
               win[k] = cand;            // First unmasked requester
            end
         end
         if (win[k] >= 0)
         begin
            exp_grants[N*k+win[k]] = 1'b1;
            exp_valid[k]           = 1'b1;
         end
      end
      // Input stalls if its target is lost or not ready
      for (int j = 0; j < N; j++)
      begin
         for (int k = 0; k < N; k++)
         begin
            if (in_request[N*k+j] && !(exp_grants[N*k+j] && out_ready[k]))
            begin
               exp_ready[j] = 1'b0;
            end
         end
      end
      if (uut.grants !== exp_grants)
         report_mismatch("grants", exp_grants, uut.grants);
      if (out_valid !== exp_valid)
         report_mismatch("out_valid", exp_valid, out_valid);
      if (in_ready !== exp_ready)
         report_mismatch("in_ready", exp_ready, in_ready);
      if ((uut.grants & mask) !== '0)
         report_mismatch("masked_grant", '0, uut.grants & mask);
      for (int k = 0; k < N; k++)
      begin
         exp_pkt = (win[k] >= 0) ? in_packet[win[k]] : '0;
         if (out_packet[k] !== exp_pkt)
            report_mismatch($sformatf("out_packet[%0d]", k), exp_pkt, out_packet[k]);
         for (int j = 0; j < N; j++)
         begin
            if (uut.grants[N*k+j] && !out_ready[k] && in_ready[j])
               report_mismatch($sformatf("stall_ready[%0d]", j), 1'b0, 1'b1);
         end
         // Stalled grant holds while requests stay put
         if (prev_ok && !prev_ready[k] && (|prev_grants[N*k+:N]) &&
             in_request[N*k+:N] == prev_req[N*k+:N] &&
             uut.grants[N*k+:N] !== prev_grants[N*k+:N])
            report_mismatch($sformatf("backpressure_hold[%0d]", k),
                            prev_grants[N*k+:N], uut.grants[N*k+:N]);
      end
      for (int j = 0; j < N; j++)
      begin
         if (active[j] && mask[N*tgt[j]+j] && in_ready[j])
            report_mismatch($sformatf("masked_ready[%0d]", j), 1'b0, 1'b1);
      end
      // Deliveries, traced by the cmd tag
      for (int k = 0; k < N; k++)
      begin
         if (out_valid[k] && out_ready[k])
         begin
            src = out_packet[k].cmd[31:24];
            dst = out_packet[k].cmd[23:16];
            sq  = out_packet[k].cmd[15:0];
            transfers++;
            if (dst != k)
               report_mismatch($sformatf("route[%0d]", k), k, dst);
            if (src >= N)
            begin
               $display("Output %0d delivered a packet from unknown input %0d", k, src);
               errors++;
            end
            else
            begin
               if (sq != deliv_cnt[src])
                  report_mismatch($sformatf("order[%0d]", src), deliv_cnt[src], sq);
               deliv_cnt[src]++;
               if (count_fair && k == 0 && in_request[N-1:0] == '1)
                  fair_cnt[src]++;       // All four contending
            end
         end
         if (win[k] >= 0 && out_ready[k])
            model_ptr[k] = (win[k] + 1) % N;
      end
      for (int j = 0; j < N; j++)
      begin
         if (active[j] && in_ready[j])
         begin
            accepted[j] = 1'b1;
            acc_cnt[j]++;
         end
         else if (active[j])
         begin
            wait_cnt[j]++;
         end
      end
      prev_req    = in_request;
      prev_grants = uut.grants;
      prev_ready  = out_ready;
      prev_ok     = 1'b1;
   endtask

   task automatic run_cycles(input int n);
      repeat (n)
      begin
         @(posedge clk);
         next_stimulus();
         @(negedge clk);
         check_cycle();
      end
   endtask

   // Five cycles low, pending requests dropped
   task automatic apply_reset();
      @(posedge clk);
      for (int j = 0; j < N; j++)
      begin
         if (accepted[j])
         begin
            seq_no[j]++;                 // Already delivered
         end
         accepted[j] = 1'b0;
         active[j]   = 1'b0;
      end
      rst_n      <= 1'b0;
      in_request <= '0;
      in_packet  <= '0;
      prev_ok     = 1'b0;
      repeat (5)
      begin
         @(negedge clk);
         if (out_valid !== '0)
            report_mismatch("reset_valid", '0, out_valid);
         @(posedge clk);
      end
      rst_n <= 1'b1;
      for (int k = 0; k < N; k++)
      begin
         model_ptr[k] = 0;
      end
   endtask

   task automatic idle_check(input int n);
      repeat (n)
      begin
         @(negedge clk);
         if (out_valid !== '0)
            report_mismatch("idle_valid", '0, out_valid);
      end
   endtask

   // ##############################
   // Phases
   // ##############################

   initial
   begin
      seed       = 32'h571bd4e1;
      clk        = 1'b0;
      rst_n      = 1'b0;
      mode       = umi_pkg::ARB_FIXED;
      mask       = '0;
      in_request = '0;
      in_packet  = '0;
      out_ready  = '0;
      errors     = 0;
      transfers  = 0;
      prev_ok    = 1'b0;
      for (int j = 0; j < N; j++)
      begin
         active[j]    = 1'b0;
         accepted[j]  = 1'b0;
         tgt[j]       = 0;
         seq_no[j]    = 0;
         wait_cnt[j]  = 0;
         acc_cnt[j]   = 0;
         deliv_cnt[j] = 0;
         fair_cnt[j]  = 0;
         model_ptr[j] = 0;
      end
      ph_mode    = umi_pkg::ARB_FIXED;
      ph_mask    = '0;
      ready_pct  = 70;
      idle_pct   = 20;
      contend    = 1'b0;
      count_fair = 1'b0;

      apply_reset();                     // Fixed priority, open paths
      idle_check(3);
      run_cycles(PHASE_CYCLES);

      ph_mode  = umi_pkg::ARB_ROUNDROBIN;  // Round robin from a fresh reset
      contend  = 1'b1;
      idle_pct = 0;
      apply_reset();
      idle_check(2);
      count_fair = 1'b1;
      @(posedge clk);
      next_stimulus();
      @(negedge clk);
      if (uut.grants[N-1:0] !== N'(1))
         report_mismatch("rr_start", N'(1), uut.grants[N-1:0]);
      check_cycle();
      run_cycles(PHASE_CYCLES / 2 - 1);
      count_fair = 1'b0;
      fmin = fair_cnt[0];
      fmax = fair_cnt[0];
      for (int j = 1; j < N; j++)
      begin
         fmin = (fair_cnt[j] < fmin) ? fair_cnt[j] : fmin;
         fmax = (fair_cnt[j] > fmax) ? fair_cnt[j] : fmax;
      end
      if (fmax - fmin > 1)
         report_mismatch("rr_fairness", 1, fmax - fmin);
      if (fmax == 0)
      begin
         $display("Round robin window saw no contended transfers on output 0");
         errors++;
      end
      contend  = 1'b0;
      idle_pct = 20;
      run_cycles(PHASE_CYCLES / 2);

      for (int i = 0; i < N * N; i++)  // Random mask, about one path in four
      begin
         ph_mask[i] = ($unsigned($random(seed)) % 4) == 0;
      end
      run_cycles(PHASE_CYCLES);

      ph_mask   = '0;                    // Heavy back-pressure
      ready_pct = 25;
      idle_pct  = 10;
      run_cycles(PHASE_CYCLES);

      for (int j = 0; j < N; j++)
      begin
         if (acc_cnt[j] != deliv_cnt[j])
            report_mismatch($sformatf("xfer_count[%0d]", j), acc_cnt[j], deliv_cnt[j]);
      end
      $display("Transfers: %0d, errors: %0d", transfers, errors);
      if (errors == 0)
      begin
         $display("Simulation finished: PASS");
      end
      else
      begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule
